/* src/phold_pkg.sv */
`default_nettype none

package phold_pkg;

   localparam int NB_LPID       = 3;
   localparam int NUM_LP        = 1 << NB_LPID;
   localparam int TIME_WID      = 16;
   localparam int NB_RND        = 8;
   localparam int OFFSET_WID    = 8;
   localparam int NB_HIST_DEPTH = 4;
   localparam int HIST_DEPTH    = 1 << NB_HIST_DEPTH;
   localparam int CNT_WID       = NB_HIST_DEPTH + 1;   // Holds 0 to HIST_DEPTH
   localparam int MIN_GAP       = 10;
   localparam int GAP_RND_BITS  = 5;

   typedef enum logic {
      REGULAR_EVT = 1'b0,
      CANCEL_EVT  = 1'b1
   } evt_kind_t;

   // Message exchanged on both handshakes
   typedef struct packed {
      evt_kind_t             kind;
      logic [NB_LPID-1:0]    lp;
      logic [TIME_WID-1:0]   tstamp;
   } evt_msg_t;

   typedef struct packed {
      evt_msg_t              msg;
      logic [TIME_WID-1:0]   gvt;
      logic [NB_RND-1:0]     rnd;
   } evt_in_t;

   // One processed event as kept in the history of its LP
   typedef struct packed {
      logic [NB_LPID-1:0]    target;   // LP the generated event went to
      logic [OFFSET_WID-1:0] offset;   // Generated time minus own time
      evt_kind_t             kind;
      logic [TIME_WID-1:0]   tstamp;
   } hist_entry_t;

   typedef enum logic [2:0] {
      IDLE,
      READ_HIST,
      GEN_EVT,
      WRITE_HIST,
      SEND_FIRST,
      SEND_RBK_CNCL,
      SEND_RBK_EVT,
      WAIT_ACK_LOW
   } fsm_state_t;

   typedef enum logic [2:0] {
      SEL_NEW,
      SEL_NULL,
      SEL_CANCEL,
      SEL_RBK_CNCL,
      SEL_RBK_EVT
   } out_sel_t;

endpackage

`default_nettype wire

/* src/phold_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module phold_fsm (
   input  logic                clk,
   input  logic                rst,
   input  logic                ev_req,
   output logic                ev_ack,
   output logic                out_req,
   input  logic                out_ack,
   input  logic                cur_last,
   input  logic                cur_empty,
   output logic                cur_clr,
   output logic                cur_inc,
   output logic                cur_load,
   output logic                rd_phase,
   output logic                wr_phase,
   output logic                capture,
   output logic                gen,
   input  logic                discard_cur,
   input  logic                cancel_valid,
   input  logic                rbk_empty,
   output logic                rbk_pop,
   output logic                keep_pop,
   output phold_pkg::out_sel_t out_sel
);
   import phold_pkg::*;

   fsm_state_t state;
   fsm_state_t state_nxt;
   logic       first_wr;    // First cycle of WRITE_HIST
   logic       evt_next;    // Rollback regular message is due next
   logic       scan_done;
   out_sel_t   first_sel;

   assign scan_done = cur_empty | cur_last;
   assign capture   = (state == IDLE) && ev_req && !ev_ack;
   assign cur_clr   = capture || (state == GEN_EVT);   // Rewind before each pass
   assign rd_phase  = (state == READ_HIST) && !cur_empty;
   assign wr_phase  = (state == WRITE_HIST);
   assign keep_pop  = wr_phase && !cur_empty;
   assign cur_inc   = (rd_phase || keep_pop) && !cur_last;
   assign cur_load  = wr_phase && first_wr;
   assign gen       = (state == GEN_EVT) && !discard_cur;
   assign rbk_pop   = (state == SEND_RBK_EVT) && out_ack;   // Entry fully sent

   // A match replaces the new event by its cancel or by the null message
   assign first_sel = discard_cur ? (cancel_valid ? SEL_CANCEL : SEL_NULL) : SEL_NEW;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (capture)
               state_nxt = READ_HIST;
         end
         READ_HIST: begin
            if (scan_done)
               state_nxt = GEN_EVT;
         end
         GEN_EVT: state_nxt = WRITE_HIST;
         WRITE_HIST: begin
            if (scan_done)
               state_nxt = SEND_FIRST;
         end
         SEND_FIRST, SEND_RBK_CNCL, SEND_RBK_EVT: begin
            if (out_ack)
               state_nxt = WAIT_ACK_LOW;
         end
         WAIT_ACK_LOW: begin
            if (!out_ack) begin
               if (evt_next)
                  state_nxt = SEND_RBK_EVT;
               else if (!rbk_empty)
                  state_nxt = SEND_RBK_CNCL;
               else
                  state_nxt = IDLE;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   // Message source, valid one cycle ahead of out_req
   always_comb begin
      case (state)
         WRITE_HIST,
         SEND_FIRST:    out_sel = first_sel;
         SEND_RBK_CNCL: out_sel = SEL_RBK_CNCL;
         SEND_RBK_EVT:  out_sel = SEL_RBK_EVT;
         WAIT_ACK_LOW:  out_sel = evt_next ? SEL_RBK_EVT : SEL_RBK_CNCL;
         default:       out_sel = SEL_NEW;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         ev_ack   <= 1'b0;
         out_req  <= 1'b0;
         first_wr <= 1'b0;
         evt_next <= 1'b0;
      end else begin
         state    <= state_nxt;
         first_wr <= (state == GEN_EVT);
         out_req  <= (state_nxt == SEND_FIRST) || (state_nxt == SEND_RBK_CNCL) ||
                     (state_nxt == SEND_RBK_EVT);
         if (capture)
            ev_ack <= 1'b1;
         else if (!ev_req)
            ev_ack <= 1'b0;   // Requester released
         if (capture)
            evt_next <= 1'b0;
         else if (state == SEND_RBK_CNCL && out_ack)
            evt_next <= 1'b1;
         else if (state == SEND_RBK_EVT && out_ack)
            evt_next <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* src/hist_cursor.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_cursor (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [phold_pkg::NB_LPID-1:0]     lp,
   input  logic                              clr,
   input  logic                              inc,
   input  logic                              load,
   input  logic [phold_pkg::CNT_WID-1:0]     keep_cnt,
   input  logic                              commit,
   output logic [phold_pkg::NB_HIST_DEPTH-1:0] cursor,
   output logic                              last,
   output logic                              empty
);
   import phold_pkg::*;

   logic [CNT_WID-1:0] lp_cnt [NUM_LP];   // Stored entries per LP
   logic [CNT_WID-1:0] keep_lim;
   logic [CNT_WID-1:0] wr_lim;
   logic [CNT_WID-1:0] limit;
   logic               wr_mode;

   // Keep count is taken straight from the FIFO in the load cycle
   assign wr_lim = load ? keep_cnt : keep_lim;
   assign limit  = (wr_mode || load) ? wr_lim : lp_cnt[lp];
   assign empty  = (limit == '0);
   assign last   = ({1'b0, cursor} == limit - 1'b1);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_LP; i++)
            lp_cnt[i] <= '0;
         cursor   <= '0;
         keep_lim <= '0;
         wr_mode  <= 1'b0;
      end else begin
         if (clr) begin
            cursor  <= '0;
            wr_mode <= 1'b0;   // Back to the stored count
         end else if (inc) begin
            cursor <= cursor + 1'b1;
         end
         if (load) begin
            keep_lim <= keep_cnt;
            wr_mode  <= 1'b1;
         end
         if (commit)
            lp_cnt[lp] <= wr_lim;
      end
   end

endmodule

`default_nettype wire

/* src/hist_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_mem (
   input  logic                                clk,
   input  logic [phold_pkg::NB_LPID-1:0]       lp,
   input  logic [phold_pkg::NB_HIST_DEPTH-1:0] cursor,
   input  logic                                wr_en,
   input  phold_pkg::hist_entry_t              wr_data,
   output phold_pkg::hist_entry_t              rd_data
);
   import phold_pkg::*;

   hist_entry_t                           mem [NUM_LP*HIST_DEPTH];
   logic [NB_LPID+NB_HIST_DEPTH-1:0]      addr;

   assign addr    = {lp, cursor};   // Each LP owns HIST_DEPTH slots
   assign rd_data = mem[addr];

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[addr] <= wr_data;
   end

endmodule

`default_nettype wire

/* src/hist_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_filter (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           capture,
   input  logic                           valid,
   input  phold_pkg::evt_msg_t            cur,
   input  logic [phold_pkg::TIME_WID-1:0] gvt,
   input  phold_pkg::hist_entry_t         entry,
   output logic                           keep_wr,
   output logic                           rbk_wr,
   output logic                           discard_cur,
   output phold_pkg::evt_msg_t            cancel_msg,
   output logic                           cancel_valid
);
   import phold_pkg::*;

   logic match_q;   // Current event annihilated by an entry
   logic hit;

   assign discard_cur = match_q;

   // First applicable rule wins
   always_comb begin
      keep_wr = 1'b0;
      rbk_wr  = 1'b0;
      hit     = 1'b0;
      if (valid) begin
         if (entry.tstamp < gvt) begin
            // Older than gvt, can never roll back
         end else if (entry.kind != cur.kind && entry.tstamp == cur.tstamp && !match_q) begin
            hit = 1'b1;
         end else if (cur.kind == REGULAR_EVT && entry.kind == REGULAR_EVT &&
                      entry.tstamp > cur.tstamp) begin
            rbk_wr = 1'b1;   // Processed too early
         end else begin
            keep_wr = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst || capture) begin
         match_q      <= 1'b0;
         cancel_valid <= 1'b0;
      end else if (hit) begin
         match_q      <= 1'b1;
         cancel_valid <= (cur.kind == CANCEL_EVT);
      end
   end

   // Undo the event this entry once generated
   always_ff @(posedge clk) begin
      if (hit) begin
         cancel_msg.kind   <= CANCEL_EVT;
         cancel_msg.lp     <= entry.target;
         cancel_msg.tstamp <= entry.tstamp + TIME_WID'(entry.offset);
      end
   end

endmodule

`default_nettype wire

/* src/hist_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_fifo (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clr,
   input  logic                          wr,
   input  logic                          rd,
   input  phold_pkg::hist_entry_t        din,
   output phold_pkg::hist_entry_t        dout,
   output logic                          empty,
   output logic [phold_pkg::CNT_WID-1:0] count
);
   import phold_pkg::*;

   hist_entry_t              mem [HIST_DEPTH];
   logic [NB_HIST_DEPTH-1:0] wr_ptr;
   logic [NB_HIST_DEPTH-1:0] rd_ptr;
   logic                     do_wr;
   logic                     do_rd;

   assign empty = (count == '0);
   assign do_wr = wr && (count != CNT_WID'(HIST_DEPTH));   // Dropped when full
   assign do_rd = rd && !empty;
   assign dout  = mem[rd_ptr];   // Head visible without a read

   always_ff @(posedge clk) begin
      if (rst || clr) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + CNT_WID'(do_wr) - CNT_WID'(do_rd);
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

endmodule

`default_nettype wire

/* src/event_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module event_gen (
   input  logic                           clk,
   input  logic                           capture,
   input  phold_pkg::evt_in_t             ev_in,
   output phold_pkg::evt_msg_t            cur,
   output logic [phold_pkg::TIME_WID-1:0] gvt,
   output phold_pkg::hist_entry_t         new_entry,
   input  phold_pkg::hist_entry_t         rbk_head,
   input  phold_pkg::evt_msg_t            cancel_msg,
   input  phold_pkg::out_sel_t            out_sel,
   output phold_pkg::evt_msg_t            out_msg
);
   import phold_pkg::*;

   logic [NB_RND-1:0]     rnd;
   logic [OFFSET_WID-1:0] gap;
   evt_msg_t              new_msg;
   evt_msg_t              null_msg;
   evt_msg_t              sel_msg;

   always_ff @(posedge clk) begin
      if (capture) begin
         cur <= ev_in.msg;
         gvt <= ev_in.gvt;
         rnd <= ev_in.rnd;
      end
   end

   // PHOLD step, gap of at least MIN_GAP
   assign gap = OFFSET_WID'(MIN_GAP) + OFFSET_WID'(rnd[GAP_RND_BITS-1:0]);
   assign new_msg   = '{kind: REGULAR_EVT, lp: rnd[NB_RND-1 -: NB_LPID],
                        tstamp: cur.tstamp + TIME_WID'(gap)};
   assign new_entry = '{target: rnd[NB_RND-1 -: NB_LPID], offset: gap,
                        kind: cur.kind, tstamp: cur.tstamp};
   assign null_msg  = '{kind: CANCEL_EVT, lp: '0, tstamp: '0};

   always_comb begin
      case (out_sel)
         SEL_NEW:      sel_msg = (cur.kind == CANCEL_EVT) ? null_msg : new_msg;
         SEL_NULL:     sel_msg = null_msg;
         SEL_CANCEL:   sel_msg = cancel_msg;
         SEL_RBK_CNCL: sel_msg = '{kind: CANCEL_EVT, lp: rbk_head.target,
                                   tstamp: rbk_head.tstamp + TIME_WID'(rbk_head.offset)};
         SEL_RBK_EVT:  sel_msg = '{kind: REGULAR_EVT, lp: cur.lp, tstamp: rbk_head.tstamp};
         default:      sel_msg = null_msg;
      endcase
   end

   // Sources hold still while a message is offered
   always_ff @(posedge clk) begin
      out_msg <= sel_msg;
   end

endmodule

`default_nettype wire

/* src/phold_core.sv */
`timescale 1ns/1ps
`default_nettype none

module phold_core (
   input  logic                clk,
   input  logic                rst,
   input  logic                ev_req,
   input  phold_pkg::evt_in_t  ev_in,
   output logic                ev_ack,
   output logic                out_req,
   output phold_pkg::evt_msg_t out_msg,
   input  logic                out_ack
);
   import phold_pkg::*;

   logic                     cur_last;
   logic                     cur_empty;
   logic                     cur_clr;
   logic                     cur_inc;
   logic                     cur_load;
   logic                     rd_phase;
   logic                     wr_phase;
   logic                     capture;
   logic                     gen;
   logic                     discard_cur;
   logic                     cancel_valid;
   logic                     rbk_empty;
   logic                     rbk_pop;
   logic                     keep_pop;
   out_sel_t                 out_sel;
   logic [NB_HIST_DEPTH-1:0] cursor;
   logic [CNT_WID-1:0]       keep_cnt;
   logic                     keep_wr;
   logic                     keep_push;
   logic                     rbk_wr;
   hist_entry_t              rd_entry;
   hist_entry_t              keep_din;
   hist_entry_t              keep_head;
   hist_entry_t              rbk_head;
   hist_entry_t              new_entry;
   evt_msg_t                 cur;
   evt_msg_t                 cancel_msg;
   logic [TIME_WID-1:0]      gvt;

   // Survivors during the read pass, then the new entry
   assign keep_push = keep_wr | gen;
   assign keep_din  = gen ? new_entry : rd_entry;

   phold_fsm u_fsm (
      .clk, .rst, .ev_req, .ev_ack, .out_req, .out_ack,
      .cur_last, .cur_empty, .cur_clr, .cur_inc, .cur_load,
      .rd_phase, .wr_phase, .capture, .gen, .discard_cur, .cancel_valid,
      .rbk_empty, .rbk_pop, .keep_pop, .out_sel
   );

   hist_cursor u_cursor (
      .clk, .rst, .lp(cur.lp), .clr(cur_clr), .inc(cur_inc), .load(cur_load),
      .keep_cnt, .commit(wr_phase), .cursor, .last(cur_last), .empty(cur_empty)
   );

   hist_mem u_mem (
      .clk, .lp(cur.lp), .cursor, .wr_en(keep_pop), .wr_data(keep_head), .rd_data(rd_entry)
   );

   hist_filter u_filter (
      .clk, .rst, .capture, .valid(rd_phase), .cur, .gvt, .entry(rd_entry),
      .keep_wr, .rbk_wr, .discard_cur, .cancel_msg, .cancel_valid
   );

   hist_fifo keep_buf (
      .clk, .rst, .clr(capture), .wr(keep_push), .rd(keep_pop), .din(keep_din),
      .dout(keep_head), .empty(), .count(keep_cnt)
   );

   hist_fifo rbk_buf (
      .clk, .rst, .clr(capture), .wr(rbk_wr), .rd(rbk_pop), .din(rd_entry),
      .dout(rbk_head), .empty(rbk_empty), .count()
   );

   event_gen u_gen (
      .clk, .capture, .ev_in, .cur, .gvt, .new_entry, .rbk_head, .cancel_msg,
      .out_sel, .out_msg
   );

endmodule

`default_nettype wire

/* tb/phold_props.sv */
`timescale 1ns/1ps
`default_nettype none

module phold_props (
   input logic                clk,
   input logic                rst,
   input logic                ev_req,
   input logic                ev_ack,
   input logic                out_req,
   input logic                out_ack,
   input phold_pkg::evt_msg_t out_msg
);
   import phold_pkg::*;

   // Message held for the whole offer
   a_msg_stable: assert property (@(posedge clk) disable iff (rst)
      out_req && !$rose(out_req) |-> $stable(out_msg))
      else $error("out_msg changed while out_req was high");

   a_req_hold: assert property (@(posedge clk) disable iff (rst)
      out_req && !out_ack |=> out_req)
      else $error("out_req dropped before out_ack");

   // Input side four-phase order
   a_ack_rise: assert property (@(posedge clk) disable iff (rst)
      $rose(ev_ack) |-> $past(ev_req))
      else $error("ev_ack rose without ev_req");

   a_ack_fall: assert property (@(posedge clk) disable iff (rst)
      $fell(ev_ack) |-> !$past(ev_req))
      else $error("ev_ack fell while ev_req was still high");

endmodule

bind phold_core phold_props u_props (.*);

`default_nettype wire

/* tb/tb_phold_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_phold_core;
   import phold_pkg::*;

   localparam int TIMEOUT_CYC = 2000;
   localparam evt_msg_t NULL_MSG = '{kind: CANCEL_EVT, lp: '0, tstamp: '0};

   logic        clk;
   logic        rst;
   logic        ev_req;
   evt_in_t     ev_in;
   logic        ev_ack;
   logic        out_req;
   evt_msg_t    out_msg;
   logic        out_ack;

   hist_entry_t model_hist [NUM_LP][HIST_DEPTH];   // Reference history per LP
   int          model_cnt  [NUM_LP];
   evt_msg_t    exp_q [$];                         // Messages still to come
   integer      seed = 32'hb012;
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   int          test_err0;
   int          ack_mask;      // Bound on the out_ack delay
   int          gvt_r;
   logic        aborted;

   phold_core DUT (
      .clk, .rst, .ev_req, .ev_in, .ev_ack, .out_req, .out_msg, .out_ack
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Cancel that undoes the event an entry once generated
   function automatic evt_msg_t undo_msg(input hist_entry_t e);
      evt_msg_t m;
      m.kind   = CANCEL_EVT;
      m.lp     = e.target;
      m.tstamp = e.tstamp + {8'd0, e.offset};
      return m;
   endfunction

   // Applies one event to the reference history and queues the expected messages
   function automatic int model_event(input evt_in_t ev);
      hist_entry_t kept [HIST_DEPTH];
      hist_entry_t rbk  [HIST_DEPTH];
      hist_entry_t e;
      evt_msg_t    first;
      evt_msg_t    cncl;
      evt_msg_t    m;
      logic        matched;
      logic        made;
      int          gap;
      int          nk;
      int          nr;
      int          lp;
      nk      = 0;
      nr      = 0;
      matched = 1'b0;
      made    = 1'b0;
      cncl    = NULL_MSG;
      lp      = ev.msg.lp;
      for (int i = 0; i < model_cnt[lp]; i++) begin
         e = model_hist[lp][i];
         if (e.tstamp < ev.gvt)
            continue;   // Expired
         if (e.kind != ev.msg.kind && e.tstamp == ev.msg.tstamp && !matched) begin
            matched = 1'b1;
            if (ev.msg.kind == CANCEL_EVT) begin
               made = 1'b1;
               cncl = undo_msg(e);
            end
         end else if (ev.msg.kind == REGULAR_EVT && e.kind == REGULAR_EVT &&
                      e.tstamp > ev.msg.tstamp) begin
            rbk[nr] = e;
            nr++;
         end else begin
            kept[nk] = e;
            nk++;
         end
      end
      gap = MIN_GAP + ev.rnd[GAP_RND_BITS-1:0];
      if (!matched && nk < HIST_DEPTH) begin
         e.target = ev.rnd[7:5];
         e.offset = gap[OFFSET_WID-1:0];
         e.kind   = ev.msg.kind;
         e.tstamp = ev.msg.tstamp;
         kept[nk] = e;
         nk++;
      end
      if (matched) begin
         first = made ? cncl : NULL_MSG;
      end else if (ev.msg.kind == CANCEL_EVT) begin
         first = NULL_MSG;
      end else begin
         first.kind   = REGULAR_EVT;
         first.lp     = ev.rnd[7:5];
         first.tstamp = ev.msg.tstamp + gap;   // Wraps at 16 bits
      end
      exp_q.push_back(first);
      for (int i = 0; i < nr; i++) begin
         exp_q.push_back(undo_msg(rbk[i]));
         m.kind   = REGULAR_EVT;
         m.lp     = ev.msg.lp;
         m.tstamp = rbk[i].tstamp;
         exp_q.push_back(m);
      end
      for (int i = 0; i < nk; i++)
         model_hist[lp][i] = kept[i];
      model_cnt[lp] = nk;
      return 1 + 2 * nr;
   endfunction

   task automatic check_msg(input evt_msg_t got);
      evt_msg_t want;
      checks++;
      if (exp_q.size() == 0) begin
         errors++;
         $display("Error at %0t: the core sent kind %0d lp %0d time %0d when no message was due",
                  $time, got.kind, got.lp, got.tstamp);
      end else begin
         want = exp_q.pop_front();
         if (got !== want) begin
            errors++;
            $display(
               "Mismatch at %0t: exp kind %0d lp %0d time %0d, got kind %0d lp %0d time %0d",
               $time, want.kind, want.lp, want.tstamp, got.kind, got.lp, got.tstamp);
         end
      end
   endtask

   // Output side, acknowledges each message after a random delay
   initial begin
      int ack_wait;
      out_ack  = 1'b0;
      ack_wait = 0;
      forever begin
         @(negedge clk);
         if (rst) begin
            out_ack = 1'b0;
         end else if (out_req && !out_ack) begin
            if (ack_wait > 0) begin
               ack_wait--;
            end else begin
               check_msg(out_msg);   // Stable while out_req is high
               out_ack = 1'b1;
            end
         end else if (!out_req && out_ack) begin
            out_ack  = 1'b0;
            ack_wait = $random(seed) & ack_mask;
         end
      end
   end

   task automatic report_timeout(input string what);
      errors++;
      aborted = 1'b1;
      ev_req  = 1'b0;
      $display("Timeout at %0t: %s", $time, what);
   endtask

   task automatic send_event(input evt_kind_t kind, input int lp, input int t,
                             input int gvt, input int rnd);
      evt_in_t ev;
      int      n;
      int      cyc;
      if (aborted)
         return;
      ev.msg.kind   = kind;
      ev.msg.lp     = lp[NB_LPID-1:0];
      ev.msg.tstamp = t[TIME_WID-1:0];
      ev.gvt        = gvt[TIME_WID-1:0];
      ev.rnd        = rnd[NB_RND-1:0];
      n = model_event(ev);
      @(negedge clk);
      ev_in  = ev;
      ev_req = 1'b1;
      cyc = 0;
      while (!ev_ack && cyc < TIMEOUT_CYC) begin
         @(negedge clk);
         cyc++;
      end
      if (!ev_ack) begin
         report_timeout("ev_ack never rose after the input request");
         return;
      end
      ev_req = 1'b0;
      cyc = 0;
      while (ev_ack && cyc < TIMEOUT_CYC) begin
         @(negedge clk);
         cyc++;
      end
      if (ev_ack) begin
         report_timeout("ev_ack stayed high after ev_req was released");
         return;
      end
      cyc = 0;
      while ((exp_q.size() != 0 || out_req || out_ack) && cyc < TIMEOUT_CYC) begin
         @(negedge clk);
         cyc++;
      end
      if (exp_q.size() != 0 || out_req || out_ack)
         report_timeout($sformatf("%0d of %0d output messages never arrived", exp_q.size(), n));
   endtask

   task automatic end_test(input string name);
      repeat (4) @(negedge clk);   // Room for a stray message to show up
      tests_run++;
      if (errors == test_err0 && !aborted) begin
         $display("Test %s: passed", name);
      end else begin
         tests_failed++;
         $display("Test %s: failed with %0d errors", name, errors - test_err0);
      end
      test_err0 = errors;
   endtask

   initial begin
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_err0    = 0;
      ack_mask     = 0;
      aborted      = 1'b0;
      rst          = 1'b1;
      ev_req       = 1'b0;
      ev_in        = '0;
      for (int i = 0; i < NUM_LP; i++)
         model_cnt[i] = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      repeat (3) begin
         checks++;
         if (ev_ack !== 1'b0 || out_req !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t: ev_ack %b out_req %b after reset, expected both low",
                     $time, ev_ack, out_req);
         end
         @(negedge clk);
      end
      for (int lp = 0; lp < NUM_LP; lp++)
         send_event(REGULAR_EVT, lp, 100 + 5 * lp, 0, 37 * lp + 11);
      end_test("1 regular events on empty LPs");

      send_event(REGULAR_EVT, 1, 200, 0, 8'h3f);
      send_event(REGULAR_EVT, 1, 210, 0, 8'ha4);
      send_event(REGULAR_EVT, 1, 220, 0, 8'h57);
      send_event(REGULAR_EVT, 1, 150, 0, 8'hc2);   // Rolls back three entries
      end_test("2 rollback of later history");

      send_event(CANCEL_EVT, 2, 110, 0, 8'h19);    // Annihilates the entry at 110
      send_event(CANCEL_EVT, 3, 300, 0, 8'h7e);
      send_event(CANCEL_EVT, 3, 300, 0, 8'h2d);
      send_event(REGULAR_EVT, 3, 300, 0, 8'hb3);   // Only one cancel entry consumed
      send_event(REGULAR_EVT, 3, 300, 0, 8'h64);
      end_test("3 cancel and regular matches");

      send_event(REGULAR_EVT, 4, 400, 0, 8'h0a);
      send_event(REGULAR_EVT, 4, 410, 0, 8'he1);
      send_event(REGULAR_EVT, 4, 300, 405, 8'h93);
      send_event(REGULAR_EVT, 5, 500, 0, 8'h4c);
      send_event(REGULAR_EVT, 5, 450, 600, 8'hd8); // Everything expired
      end_test("4 gvt drops expired entries");

      ack_mask = 7;
      gvt_r    = 700;
      for (int i = 0; i < 200; i++) begin
         int        lp;
         int        t;
         int        rnd;
         evt_kind_t kind;
         lp   = $random(seed) & 7;
         t    = gvt_r + ($random(seed) & 31);
         kind = (($random(seed) & 3) == 0) ? CANCEL_EVT : REGULAR_EVT;
         rnd  = $random(seed) & 255;
         send_event(kind, lp, t, gvt_r, rnd);
         gvt_r = gvt_r + ($random(seed) & 3);
      end
      end_test("5 random events with slow out_ack");

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0 && !aborted)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
src/phold_pkg.sv
src/phold_fsm.sv
src/hist_cursor.sv
src/hist_mem.sv
src/hist_filter.sv
src/hist_fifo.sv
src/event_gen.sv
src/phold_core.sv
tb/phold_props.sv
tb/tb_phold_core.sv
